/* source/angle_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// full turn is 4096 counts; the table index keeps half of that resolution
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package angle_pkg;

    localparam int angle_width = 12;
    localparam int octant_width = 3;
    localparam int index_width = 9;

    // angle counts at the octant boundaries used for folding
    localparam int quarter_turn = 1024;
    localparam int half_turn = 2 * quarter_turn;
    localparam int three_quarter_turn = 3 * quarter_turn;
    localparam int full_turn = 4 * quarter_turn;

    typedef logic [angle_width-1:0] angle_t;
    typedef logic [octant_width-1:0] octant_t;
    typedef logic [index_width-1:0] index_t;

endpackage

/* source/table_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// banks span 0 to 45 degrees in Q2.14; entry 0 of the cosine bank is 1.0
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package table_pkg;

    localparam int mag_width = 15;
    localparam int result_width = 16;
    localparam int unit_scale = 16384;
    localparam int table_depth = 257;

    typedef logic [mag_width-1:0] mag_t;
    typedef logic signed [result_width-1:0] result_t;
    typedef mag_t bank_t [table_depth];

    localparam real pi = 3.14159265358979323846;
    // table_depth - 1 steps cover one eighth of a turn
    localparam real index_step = pi / real'(4 * (table_depth - 1));

    // sine = 1 selects the sine bank, otherwise cosine
    function automatic bank_t build_bank(input logic sine);
        bank_t bank;
        real phase;
        real sample;
        int i;
        for (i = 0; i < table_depth; i++) begin
            phase = real'(i) * index_step;
            if (sine) begin
                sample = real'(unit_scale) * $sin(phase);
            end else begin
                sample = real'(unit_scale) * $cos(phase);
            end
            // round half up for non-negative samples
            bank[i] = mag_t'($rtoi(sample + 0.5));
        end
        return bank;
    endfunction

endpackage

/* source/fold_iface.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// valid is a one-cycle pulse; the other fields hold until the next one
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

interface fold_iface import angle_pkg::*; ();

    logic valid;
    index_t table_index;
    logic cos_bank;
    logic negate;

    modport source (output valid, output table_index, output cos_bank, output negate);

    modport sink (input valid, input table_index, input cos_bank, input negate);

endinterface

/* source/request_gate.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// four-phase req/ack; one item in flight, next req only after ack drops
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module request_gate (
    input  logic clk,
    input  logic reset,
    input  logic req,
    input  logic result_valid,
    output logic accept,
    output logic ack
);

    typedef enum logic [1:0] {idle, busy, acked} gate_state_t;

    gate_state_t state;

    // req can only be taken while nothing is in flight
    assign accept = (state == idle) && req;
    assign ack = (state == acked);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (req) begin
                        state <= busy;
                    end
                end
                busy: begin
                    if (result_valid) begin
                        state <= acked;
                    end
                end
                acked: begin
                    // hold ack and result until the requester lets go
                    if (!req) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

/* source/octant_fold.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// angle and cos_en are sampled only on accept
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module octant_fold import angle_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic accept,
    input  logic cos_en,
    input  angle_t angle,
    fold_iface.source fold
);

    angle_t eff_angle;
    octant_t octant;
    angle_t reduced;
    logic next_cos_bank;
    logic next_negate;

    // sin(a) = cos(quarter turn - a)
    assign eff_angle = cos_en ? angle : angle_t'(quarter_turn - int'(angle));
    assign octant = eff_angle[angle_width-1 -: octant_width];

    always_comb begin
        case (octant)
            3'd0: begin
                reduced = eff_angle;
                next_cos_bank = 1'b1;
                next_negate = 1'b0;
            end
            3'd1: begin
                reduced = angle_t'(quarter_turn - int'(eff_angle));
                next_cos_bank = 1'b0;
                next_negate = 1'b0;
            end
            3'd2: begin
                reduced = angle_t'(int'(eff_angle) - quarter_turn);
                next_cos_bank = 1'b0;
                next_negate = 1'b1;
            end
            3'd3: begin
                reduced = angle_t'(half_turn - int'(eff_angle));
                next_cos_bank = 1'b1;
                next_negate = 1'b1;
            end
            3'd4: begin
                reduced = angle_t'(int'(eff_angle) - half_turn);
                next_cos_bank = 1'b1;
                next_negate = 1'b1;
            end
            3'd5: begin
                reduced = angle_t'(three_quarter_turn - int'(eff_angle));
                next_cos_bank = 1'b0;
                next_negate = 1'b1;
            end
            3'd6: begin
                reduced = angle_t'(int'(eff_angle) - three_quarter_turn);
                next_cos_bank = 1'b0;
                next_negate = 1'b0;
            end
            default: begin
                reduced = angle_t'(full_turn - int'(eff_angle));
                next_cos_bank = 1'b1;
                next_negate = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fold.valid <= 1'b0;
        end else begin
            fold.valid <= accept;
        end
    end

    // table index drops the lowest bit of the 0..512 reduced angle
    always_ff @(posedge clk) begin
        if (accept) begin
            fold.table_index <= reduced[index_width:1];
            fold.cos_bank <= next_cos_bank;
            fold.negate <= next_negate;
        end
    end

endmodule

/* source/quarter_wave_rom.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// both banks are constant ROMs built at elaboration; one cycle read
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module quarter_wave_rom import table_pkg::*; (
    input  logic clk,
    input  logic reset,
    fold_iface.sink fold,
    output logic valid,
    output mag_t magnitude,
    output logic negate
);

    localparam bank_t cos_rom = build_bank(1'b0);
    localparam bank_t sin_rom = build_bank(1'b1);

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else begin
            valid <= fold.valid;
        end
    end

    // magnitude and sign move together with valid
    always_ff @(posedge clk) begin
        if (fold.valid) begin
            if (fold.cos_bank) begin
                magnitude <= cos_rom[fold.table_index];
            end else begin
                magnitude <= sin_rom[fold.table_index];
            end
            negate <= fold.negate;
        end
    end

endmodule

/* source/sign_restore.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// result holds its value between items; -1.0 is the most negative output
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module sign_restore import table_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic valid,
    input  mag_t magnitude,
    input  logic negate,
    output result_t result,
    output logic result_valid
);

    result_t mag_ext;

    // zero extend the unsigned magnitude
    assign mag_ext = result_t'({1'b0, magnitude});

    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= valid;
            if (valid) begin
                result <= negate ? -mag_ext : mag_ext;
            end
        end
    end

endmodule

/* source/sincos_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// hold cos_en and angle stable while req is high; ack 3 cycles after accept
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module sincos_top import angle_pkg::*, table_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic req,
    input  logic cos_en,
    input  angle_t angle,
    output logic ack,
    output result_t result
);

    logic accept;
    logic result_valid;
    logic rom_valid;
    mag_t rom_magnitude;
    logic rom_negate;

    fold_iface fold_if ();

    request_gate request_gate_i (
        .clk          (clk),
        .reset        (reset),
        .req          (req),
        .result_valid (result_valid),
        .accept       (accept),
        .ack          (ack)
    );

    // stage 1
    octant_fold octant_fold_i (
        .clk    (clk),
        .reset  (reset),
        .accept (accept),
        .cos_en (cos_en),
        .angle  (angle),
        .fold   (fold_if.source)
    );

    // stage 2
    quarter_wave_rom quarter_wave_rom_i (
        .clk       (clk),
        .reset     (reset),
        .fold      (fold_if.sink),
        .valid     (rom_valid),
        .magnitude (rom_magnitude),
        .negate    (rom_negate)
    );

    // stage 3
    sign_restore sign_restore_i (
        .clk          (clk),
        .reset        (reset),
        .valid        (rom_valid),
        .magnitude    (rom_magnitude),
        .negate       (rom_negate),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

/* tests/sincos_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// drives the req/ack port on falling edges; stops at the first mismatch
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module sincos_tb;

    localparam int reset_cycles = 3;
    localparam int num_directed = 2 * 24 + 4;
    localparam int num_random = 400;
    localparam int num_txn = num_directed + num_random;
    localparam int cycle_budget = num_txn * 12 + 1000;
    localparam int ack_timeout = 20;

    // angle counts and Q2.14 scale of the reference model
    localparam int full_turn_ref = 4096;
    localparam int quarter_turn_ref = 1024;
    localparam int octant_span = 512;
    localparam real scale_ref = 16384.0;
    localparam real pi_ref = 3.14159265358979323846;

    logic clk;
    logic reset;
    logic req;
    logic cos_en;
    logic [11:0] angle;
    logic ack;
    logic signed [15:0] result;

    logic [31:0] rng_state;
    int compared;
    int last_result;
    logic ack_seen;

    sincos_top sincos_top_i (
        .clk    (clk),
        .reset  (reset),
        .req    (req),
        .cos_en (cos_en),
        .angle  (angle),
        .ack    (ack),
        .result (result)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // fold, halve to the table index, round the sample, restore the sign
    function automatic int expected_result(input int a, input logic use_cos);
        int eff;
        int oct;
        int reduced;
        int idx;
        int mag;
        logic sine_bank;
        logic neg;
        real phase;
        if (use_cos) begin
            eff = a;
        end else begin
            eff = (quarter_turn_ref - a + full_turn_ref) % full_turn_ref;
        end
        oct = eff / octant_span;
        // even octants count up from their start, odd ones down from their end
        if (oct % 2 == 0) begin
            reduced = eff - oct * octant_span;
        end else begin
            reduced = (oct + 1) * octant_span - eff;
        end
        sine_bank = (oct == 1) || (oct == 2) || (oct == 5) || (oct == 6);
        neg = (oct >= 2) && (oct <= 5);
        idx = reduced / 2;
        phase = real'(idx) * (pi_ref / real'(1024));
        if (sine_bank) begin
            mag = $rtoi(scale_ref * $sin(phase) + 0.5);
        end else begin
            mag = $rtoi(scale_ref * $cos(phase) + 0.5);
        end
        return neg ? -mag : mag;
    endfunction

    task automatic check_value(input string name, input int actual, input int expected);
        if (actual != expected) begin
            $display("[ERROR] time=%0t %s: got %0d, expected %0d", $time, name, actual,
                     expected);
            $display("SIMULATION FAILED");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic draw_random(output logic [31:0] value);
        rng_state = xorshift32(rng_state);
        value = rng_state;
    endtask

    // called at a falling edge with ack low; returns at a falling edge with ack low
    task automatic run_item(input int a, input logic use_cos);
        int waited;
        int hold;
        int held_result;
        logic [31:0] r;
        angle = 12'(a);
        cos_en = use_cos;
        req = 1'b1;
        waited = 0;
        while (!ack && waited < ack_timeout) begin
            @(negedge clk);
            waited++;
        end
        if (!ack) begin
            $display("ack never rose for angle %0d within %0d cycles", a, ack_timeout);
            $display("SIMULATION FAILED");
            $fatal(1, "handshake stalled");
        end
        // first rising edge after req is the accepting edge
        check_value("ack_latency", waited - 1, 3);
        held_result = int'(result);
        last_result = held_result;
        draw_random(r);
        hold = int'(r % 32'd9);
        repeat (hold) begin
            @(negedge clk);
            check_value("ack", int'(ack), 1);
            check_value("result", int'(result), held_result);
        end
        req = 1'b0;
        @(negedge clk);
        check_value("ack", int'(ack), 0);
        check_value("result", int'(result), held_result);
    endtask

    // compare on each rising ack while the requester still holds the inputs
    always @(negedge clk) begin
        if (!reset && ack && !ack_seen) begin
            check_value("result", int'(result), expected_result(int'(angle), cos_en));
            compared++;
        end
        ack_seen = ack;
    end

    initial begin
        repeat (reset_cycles + cycle_budget) @(posedge clk);
        $display("watchdog timeout after %0d cycles, run did not finish", cycle_budget);
        $display("SIMULATION FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int k;
        int m;
        int offs [3];
        logic [31:0] r;
        clk = 1'b0;
        reset = 1'b1;
        req = 1'b0;
        cos_en = 1'b1;
        angle = '0;
        rng_state = 32'he3143d44;
        compared = 0;
        last_result = 0;
        ack_seen = 1'b0;
        offs[0] = 0;
        offs[1] = 256;
        offs[2] = 511;

        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_value("ack", int'(ack), 0);
        check_value("result", int'(result), 0);

        // cosine, then sine, at start, middle and end of each octant
        for (m = 0; m < 2; m++) begin
            for (k = 0; k < 24; k++) begin
                run_item((k / 3) * octant_span + offs[k % 3], m == 0);
            end
        end

        run_item(0, 1'b1);
        check_value("result", last_result, 16384);
        run_item(2048, 1'b1);
        check_value("result", last_result, -16384);
        run_item(1024, 1'b0);
        check_value("result", last_result, 16384);
        run_item(3072, 1'b0);
        check_value("result", last_result, -16384);

        for (k = 0; k < num_random; k++) begin
            draw_random(r);
            run_item(int'(r[11:0]), r[12]);
        end

        @(negedge clk);
        if (compared == num_txn) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("expected %0d compared results, saw %0d", num_txn, compared);
            $display("SIMULATION FAILED");
            $fatal(1, "result count mismatch");
        end
    end

endmodule

/* files.f */
source/angle_pkg.sv
source/table_pkg.sv
source/fold_iface.sv
source/request_gate.sv
source/octant_fold.sv
source/quarter_wave_rom.sv
source/sign_restore.sv
source/sincos_top.sv
tests/sincos_tb.sv

/* Makefile */
VERILATOR ?= verilator
LINT_FLAGS = --lint-only --timing
SIM_FLAGS = --binary --timing
TOP = sincos_tb
FILELIST = files.f
OBJ_DIR = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
